/* src/mem_pkg.sv */
package mem_pkg;

  localparam int CYCLE_LEN   = 4;  // fclk per dram cycle
  localparam int NUM_WINDOWS = 4;
  localparam int WINDOW_BITS = 14; // 16k window

  // cpu side
  typedef logic [15:0] zaddr_t;
  typedef logic [7:0]  zbyte_t;
  typedef logic [7:0]  page_t;
  typedef logic [1:0]  win_sel_t;

  // dram side
  // bit 20 picks the ras bank, then row 19..10, column 9..0
  typedef logic [20:0] word_addr_t;
  typedef logic [15:0] dram_word_t;
  typedef logic [9:0]  ra_t;
  typedef logic [1:0]  bsel_t;     // [1] upper byte, [0] lower byte

  typedef enum logic [1:0] {
    PH0,
    PH1,
    PH2,
    PH3
  } phase_t;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_CPU,
    OWN_DMA
  } owner_t;

endpackage

/* src/dram_phase.sv */
`timescale 1ns/1ps

module dram_phase import mem_pkg::*; (
  input  logic fclk,
  input  logic arst_n,
  output logic c0,
  output logic c1,
  output logic c2,
  output logic c3
);

  phase_t phase;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= PH0;
    end else begin
      phase <= phase_t'(phase + 2'd1); // wraps PH3 -> PH0
    end
  end

  assign c0 = (phase == PH0);
  assign c1 = (phase == PH1);
  assign c2 = (phase == PH2);
  assign c3 = (phase == PH3);

  a_phase_onehot: assert property (@(posedge fclk) disable iff (!arst_n)
    $onehot({c0, c1, c2, c3}));

endmodule

/* src/page_map.sv */
`timescale 1ns/1ps

module page_map import mem_pkg::*; (
  input  logic       fclk,
  input  logic       arst_n,
  input  logic       page_wr,
  input  win_sel_t   page_win,
  input  page_t      page_data,
  input  zaddr_t     cpu_addr,
  input  logic       cpu_rnw,
  output word_addr_t cpu_waddr,
  output bsel_t      cpu_bsel
);

  page_t    pages [NUM_WINDOWS];
  win_sel_t win;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_WINDOWS; i++) begin
        pages[i] <= '0;
      end
    end else if (page_wr) begin
      pages[page_win] <= page_data;
    end
  end

  // top two address bits pick the window
  assign win = cpu_addr[15:WINDOW_BITS];

  // page, then word offset inside the window
  assign cpu_waddr = {pages[win], cpu_addr[WINDOW_BITS-1:1]};

  // reads fetch the whole word, writes hit one lane
  always_comb begin
    if (cpu_rnw) begin
      cpu_bsel = 2'b11;
    end else if (cpu_addr[0]) begin
      cpu_bsel = 2'b10; // odd byte is the upper lane
    end else begin
      cpu_bsel = 2'b01;
    end
  end

endmodule

/* src/dram_arbiter.sv */
`timescale 1ns/1ps

module dram_arbiter import mem_pkg::*; (
  input  logic       fclk,
  input  logic       arst_n,
  input  logic       c3,
  // cpu requester
  input  logic       cpu_req,
  input  logic       cpu_rnw,
  input  word_addr_t cpu_waddr,
  input  bsel_t      cpu_bsel,
  input  zbyte_t     cpu_wrdata,
  // dma requester
  input  logic       dma_req,
  input  logic       dma_rnw,
  input  word_addr_t dma_addr,
  input  dram_word_t dma_wrdata,
  output logic       cpu_next,
  output logic       dma_next,
  output logic       cpu_strobe,
  output logic       dma_strobe,
  // cycle for the controller
  output logic       cyc_valid,
  output logic       cyc_rnw,
  output word_addr_t cyc_addr,
  output bsel_t      cyc_bsel,
  output dram_word_t cyc_wrdata
);

  owner_t owner; // owner of the cycle now on the pins
  logic   cpu_win;
  logic   dma_win;

  // fixed priority, cpu first
  assign cpu_win = c3 & cpu_req;
  assign dma_win = c3 & ~cpu_req & dma_req;

  assign cpu_next = cpu_win;
  assign dma_next = dma_win;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      cyc_valid <= 1'b0;
      owner     <= OWN_NONE;
    end else if (c3) begin
      cyc_valid <= cpu_win | dma_win;
      if (cpu_win)
        owner <= OWN_CPU;
      else if (dma_win)
        owner <= OWN_DMA;
      else
        owner <= OWN_NONE;
    end
  end

  always_ff @(posedge fclk) begin
    if (cpu_win) begin
      cyc_addr   <= cpu_waddr;
      cyc_rnw    <= cpu_rnw;
      cyc_bsel   <= cpu_bsel;
      cyc_wrdata <= {cpu_wrdata, cpu_wrdata}; // byte on both lanes
    end else if (dma_win) begin
      cyc_addr   <= dma_addr;
      cyc_rnw    <= dma_rnw;
      cyc_bsel   <= 2'b11;
      cyc_wrdata <= dma_wrdata;
    end
  end

  // rddata is valid in ph3, done before the owner changes
  assign cpu_strobe = c3 & (owner == OWN_CPU);
  assign dma_strobe = c3 & (owner == OWN_DMA);

  a_next_excl: assert property (@(posedge fclk) disable iff (!arst_n)
    !(cpu_next && dma_next) && ((cpu_next || dma_next) -> c3));

  a_cpu_done: assert property (@(posedge fclk) disable iff (!arst_n)
    cpu_next |-> ##CYCLE_LEN cpu_strobe);

  a_dma_done: assert property (@(posedge fclk) disable iff (!arst_n)
    dma_next |-> ##CYCLE_LEN dma_strobe);

endmodule

/* src/dram_ctrl.sv */
`timescale 1ns/1ps

module dram_ctrl import mem_pkg::*; (
  input  logic       fclk,
  input  logic       arst_n,
  input  logic       c0,
  input  logic       c1,
  input  logic       c2,
  input  logic       c3,
  input  logic       cyc_valid,
  input  logic       cyc_rnw,
  input  word_addr_t cyc_addr,
  input  bsel_t      cyc_bsel,
  input  dram_word_t cyc_wrdata,
  input  dram_word_t rd,
  output ra_t        ra,
  output dram_word_t dram_wd,
  output logic       dram_wd_oe,
  output logic       rwe_n,
  output logic       rucas_n,
  output logic       rlcas_n,
  output logic       rras0_n,
  output logic       rras1_n,
  output dram_word_t rddata
);

  logic ras_act;
  logic cas_act;
  logic wr_act;
  logic bank;

  assign bank = cyc_addr[20];

  // ras held from ph0 through ph2, released in ph3
  assign ras_act = cyc_valid & ~c3;
  assign cas_act = cyc_valid & (c1 | c2);
  assign wr_act  = cas_act & ~cyc_rnw;

  // row in ph0, column after
  assign ra = c0 ? ra_t'(cyc_addr[19:10]) : ra_t'(cyc_addr[9:0]);

  assign rras0_n = ~(ras_act & ~bank);
  assign rras1_n = ~(ras_act & bank);

  // a read always takes both bytes
  assign rucas_n = ~(cas_act & (cyc_rnw | cyc_bsel[1]));
  assign rlcas_n = ~(cas_act & (cyc_rnw | cyc_bsel[0]));

  assign rwe_n      = ~wr_act;
  assign dram_wd_oe = wr_act;
  assign dram_wd    = cyc_wrdata;

  // sample at end of ph2, valid during ph3
  always_ff @(posedge fclk) begin
    if (c2 && cyc_valid && cyc_rnw) begin
      rddata <= rd;
    end
  end

  a_one_bank: assert property (@(posedge fclk) disable iff (!arst_n)
    !(!rras0_n && !rras1_n));

  // cas only under an open row
  a_cas_in_ras: assert property (@(posedge fclk) disable iff (!arst_n)
    (!rucas_n || !rlcas_n) |-> (!rras0_n || !rras1_n));

endmodule

/* src/zx_mem_core.sv */
`timescale 1ns/1ps

module zx_mem_core import mem_pkg::*; (
  input  logic       fclk,
  input  logic       arst_n,
  // cpu
  input  logic       cpu_req,
  input  logic       cpu_rnw,
  input  zaddr_t     cpu_addr,
  input  zbyte_t     cpu_wrdata,
  output logic       cpu_next,
  output logic       cpu_strobe,
  // dma
  input  logic       dma_req,
  input  logic       dma_rnw,
  input  word_addr_t dma_addr,
  input  dram_word_t dma_wrdata,
  output logic       dma_next,
  output logic       dma_strobe,
  // page registers
  input  logic       page_wr,
  input  win_sel_t   page_win,
  input  page_t      page_data,
  // dram
  input  dram_word_t rd,
  output ra_t        ra,
  output dram_word_t dram_wd,
  output logic       dram_wd_oe,
  output logic       rwe_n,
  output logic       rucas_n,
  output logic       rlcas_n,
  output logic       rras0_n,
  output logic       rras1_n,
  output dram_word_t rddata
);

  logic       c0, c1, c2, c3;
  word_addr_t cpu_waddr;
  bsel_t      cpu_bsel;
  logic       cyc_valid;
  logic       cyc_rnw;
  word_addr_t cyc_addr;
  bsel_t      cyc_bsel;
  dram_word_t cyc_wrdata;

  dram_phase u_phase (
    .fclk(fclk), .arst_n(arst_n), .c0(c0), .c1(c1), .c2(c2), .c3(c3)
  );

  page_map u_page_map (
    .fclk(fclk), .arst_n(arst_n), .page_wr(page_wr), .page_win(page_win),
    .page_data(page_data), .cpu_addr(cpu_addr), .cpu_rnw(cpu_rnw),
    .cpu_waddr(cpu_waddr), .cpu_bsel(cpu_bsel)
  );

  dram_arbiter u_arbiter (
    .fclk(fclk), .arst_n(arst_n), .c3(c3),
    .cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_waddr(cpu_waddr),
    .cpu_bsel(cpu_bsel), .cpu_wrdata(cpu_wrdata),
    .dma_req(dma_req), .dma_rnw(dma_rnw), .dma_addr(dma_addr), .dma_wrdata(dma_wrdata),
    .cpu_next(cpu_next), .dma_next(dma_next),
    .cpu_strobe(cpu_strobe), .dma_strobe(dma_strobe),
    .cyc_valid(cyc_valid), .cyc_rnw(cyc_rnw), .cyc_addr(cyc_addr),
    .cyc_bsel(cyc_bsel), .cyc_wrdata(cyc_wrdata)
  );

  dram_ctrl u_ctrl (
    .fclk(fclk), .arst_n(arst_n), .c0(c0), .c1(c1), .c2(c2), .c3(c3),
    .cyc_valid(cyc_valid), .cyc_rnw(cyc_rnw), .cyc_addr(cyc_addr),
    .cyc_bsel(cyc_bsel), .cyc_wrdata(cyc_wrdata), .rd(rd),
    .ra(ra), .dram_wd(dram_wd), .dram_wd_oe(dram_wd_oe), .rwe_n(rwe_n),
    .rucas_n(rucas_n), .rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n),
    .rddata(rddata)
  );

endmodule

/* bench/dram_model.sv */
`timescale 1ns/1ps

module dram_model import mem_pkg::*; (
  input  logic       fclk,
  input  ra_t        ra,
  input  logic       rras0_n,
  input  logic       rras1_n,
  input  logic       rucas_n,
  input  logic       rlcas_n,
  input  logic       rwe_n,
  input  dram_word_t dram_wd,
  input  logic       dram_wd_oe,
  output dram_word_t rd
);

  localparam int DEPTH = 1 << 21;

  dram_word_t mem [0:DEPTH-1];
  ra_t        row;
  logic       bank;
  dram_word_t rd_q;
  word_addr_t addr;

  // unwritten words read back a pattern of their whole address
  function automatic dram_word_t fill(input word_addr_t a);
    return a[15:0] ^ {a[20:16], a[20:16], a[20:16], 1'b1};
  endfunction

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = fill(word_addr_t'(i));
    end
    rd_q = '0;
  end

  assign addr = {bank, row, ra};

  always @(posedge fclk) begin
    if ((!rras0_n || !rras1_n) && rucas_n && rlcas_n) begin
      row  <= ra;      // row strobe, no cas yet
      bank <= rras0_n; // bank 1 when ras0 idle
    end
    if (!rucas_n || !rlcas_n) begin
      if (!rwe_n) begin
        if (!rucas_n) mem[addr][15:8] <= rd[15:8]; // data taken off the shared bus
        if (!rlcas_n) mem[addr][7:0] <= rd[7:0];
      end else begin
        rd_q[15:8] <= rucas_n ? 8'hxx : mem[addr][15:8]; // lane without cas floats
        rd_q[7:0]  <= rlcas_n ? 8'hxx : mem[addr][7:0];
      end
    end
  end

  // shared data bus
  assign rd = dram_wd_oe ? dram_wd : rd_q;

endmodule

/* bench/tb_zx_mem_core.sv */
`timescale 1ns/1ps

module tb_zx_mem_core import mem_pkg::*; ();

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 5;
  localparam int STROBE_DELAY = 4; // next to strobe, one dram cycle
  localparam int WAIT_LIMIT   = 40;
  localparam int POOL         = 8;

  logic       fclk;
  logic       arst_n;
  logic       cpu_req, cpu_rnw, cpu_next, cpu_strobe;
  zaddr_t     cpu_addr;
  zbyte_t     cpu_wrdata;
  logic       dma_req, dma_rnw, dma_next, dma_strobe;
  word_addr_t dma_addr;
  dram_word_t dma_wrdata, rd, dram_wd, rddata;
  logic       page_wr;
  win_sel_t   page_win;
  page_t      page_data;
  ra_t        ra;
  logic       dram_wd_oe, rwe_n, rucas_n, rlcas_n, rras0_n, rras1_n;
  int         errors = 0;
  integer     seed = 32'h88b60ce0;

  zx_mem_core uut (.*);
  dram_model mem (.*);

  always #HALF_PERIOD fclk = ~fclk;

  task automatic check_word(input string name, input dram_word_t exp, input dram_word_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_pin(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic fail_plain(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_timeout(input string what);
    errors++;
    $display("timeout waiting for %s at %0t ns", what, $time);
    $display("errors: %0d", errors);
    $display("Something failed");
    $finish;
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // page rule: page of the window, then cpu bits 13..1
  function automatic word_addr_t map_addr(input page_t p, input zaddr_t ca);
    return {p, ca[13:1]};
  endfunction

  function automatic dram_word_t merge_byte(input dram_word_t old, input zaddr_t ca,
                                            input zbyte_t b);
    return ca[0] ? {b, old[7:0]} : {old[15:8], b};
  endfunction

  // one request through next and strobe, sampled just after the falling edge
  task automatic access(input logic use_cpu, input logic rnw, input word_addr_t daddr,
                        input zaddr_t caddr, input dram_word_t wdata,
                        output dram_word_t data);
    int n;
    @(negedge fclk);
    if (use_cpu) begin
      cpu_req = 1'b1;
      cpu_rnw = rnw;
      cpu_addr = caddr;
      cpu_wrdata = wdata[7:0];
    end else begin
      dma_req = 1'b1;
      dma_rnw = rnw;
      dma_addr = daddr;
      dma_wrdata = wdata;
    end
    n = 0;
    #1;
    while (!(use_cpu ? cpu_next : dma_next)) begin
      if (n == WAIT_LIMIT) abort_timeout(use_cpu ? "cpu_next" : "dma_next");
      @(negedge fclk);
      #1;
      n++;
    end
    @(negedge fclk);
    if (use_cpu) cpu_req = 1'b0;
    else dma_req = 1'b0;
    n = 1;
    #1;
    while (!(use_cpu ? cpu_strobe : dma_strobe)) begin
      if (n == WAIT_LIMIT) abort_timeout(use_cpu ? "cpu_strobe" : "dma_strobe");
      @(negedge fclk);
      #1;
      n++;
    end
    if (n != STROBE_DELAY)
      fail_plain($sformatf("strobe came %0d cycles after next instead of %0d", n, STROBE_DELAY));
    data = rddata;
  endtask

  task automatic dma_write(input word_addr_t a, input dram_word_t w);
    dram_word_t unused;
    access(1'b0, 1'b0, a, '0, w, unused);
  endtask

  task automatic dma_read(input word_addr_t a, output dram_word_t w);
    access(1'b0, 1'b1, a, '0, '0, w);
  endtask

  task automatic cpu_write(input zaddr_t ca, input zbyte_t b);
    dram_word_t unused;
    access(1'b1, 1'b0, '0, ca, {8'h00, b}, unused);
  endtask

  task automatic cpu_read(input zaddr_t ca, output dram_word_t w);
    access(1'b1, 1'b1, '0, ca, '0, w);
  endtask

  task automatic set_page(input win_sel_t w, input page_t p);
    @(negedge fclk);
    page_wr = 1'b1;
    page_win = w;
    page_data = p;
    @(negedge fclk);
    page_wr = 1'b0;
  endtask

  task automatic test_reset();
    check_pin("rras0_n", 1'b1, rras0_n);
    check_pin("rras1_n", 1'b1, rras1_n);
    check_pin("rucas_n", 1'b1, rucas_n);
    check_pin("rlcas_n", 1'b1, rlcas_n);
    check_pin("rwe_n", 1'b1, rwe_n);
    check_pin("cpu_next", 1'b0, cpu_next);
    check_pin("dma_next", 1'b0, dma_next);
    check_pin("cpu_strobe", 1'b0, cpu_strobe);
    check_pin("dma_strobe", 1'b0, dma_strobe);
    check_pin("dram_wd_oe", 1'b0, dram_wd_oe);
  endtask

  task automatic test_dma_round_trip();
    logic [31:0] r;
    dram_word_t  got;
    r = rand32();
    dma_write(r[20:0], r[31:16]);
    dma_read(r[20:0], got);
    check_word("rddata", r[31:16], got);
  endtask

  task automatic test_cpu_paging();
    logic [31:0] r;
    page_t       p;
    zaddr_t      ca;
    dram_word_t  exp, got;
    r = rand32();
    p = r[7:0];
    ca = {2'b10, r[21:9], 1'b0};
    exp = r[31:16];
    set_page(2, p);
    dma_write(map_addr(p, ca), exp);
    for (int lane = 0; lane < 2; lane++) begin
      r = rand32();
      ca[0] = lane[0];
      cpu_write(ca, r[7:0]);
      exp = merge_byte(exp, ca, r[7:0]); // other lane untouched
      dma_read(map_addr(p, ca), got);
      check_word("rddata", exp, got);
    end
  endtask

  task automatic test_page_remap();
    logic [31:0] r;
    logic [31:0] base;
    page_t       pa, pb;
    zaddr_t      ca;
    zbyte_t      b;
    dram_word_t  got;
    r = rand32();
    base = rand32();
    pa = r[7:0];
    pb = pa + 8'd1;
    ca = {2'b11, r[20:8], 1'b1};
    b = r[31:24];
    dma_write(map_addr(pa, ca), base[15:0]);
    dma_write(map_addr(pb, ca), base[31:16]);
    set_page(3, pa);
    cpu_write(ca, b);
    set_page(3, pb);
    cpu_write(ca, ~b);
    set_page(3, pa);
    cpu_read(ca, got);
    check_word("rddata", merge_byte(base[15:0], ca, b), got);
    set_page(3, pb);
    cpu_read(ca, got);
    check_word("rddata", merge_byte(base[31:16], ca, ~b), got);
  endtask

  task automatic test_contention();
    logic [31:0] r;
    page_t       p;
    zaddr_t      ca;
    word_addr_t  da;
    dram_word_t  base, got;
    int          cyc, cn, dn, cs, ds;
    r = rand32();
    p = r[7:0];
    ca = {2'b00, r[20:8], 1'b1};
    da = map_addr(p, ca) ^ 21'h1; // neighbour word
    base = r[31:16];
    set_page(0, p);
    dma_write(map_addr(p, ca), base);
    cn = -1;
    dn = -1;
    cs = -1;
    ds = -1;
    cyc = 0;
    @(negedge fclk);
    cpu_req = 1'b1;
    cpu_rnw = 1'b0;
    cpu_addr = ca;
    cpu_wrdata = r[7:0];
    dma_req = 1'b1;
    dma_rnw = 1'b0;
    dma_addr = da;
    dma_wrdata = ~base;
    #1;
    while (ds < 0) begin
      if (cyc == WAIT_LIMIT) abort_timeout("the strobes of the contended writes");
      if (cpu_next && cn < 0) cn = cyc;
      if (dma_next && dn < 0) dn = cyc;
      if (cpu_strobe) cs = cyc;
      if (dma_strobe) ds = cyc;
      @(negedge fclk);
      if (cn >= 0) cpu_req = 1'b0;
      if (dn >= 0) dma_req = 1'b0;
      #1;
      cyc++;
    end
    if (cn < 0 || dn != cn + STROBE_DELAY)
      fail_plain("dma_next did not come one DRAM cycle after cpu_next");
    if (cs != cn + STROBE_DELAY || ds != dn + STROBE_DELAY)
      fail_plain("a strobe of the contended pair came in the wrong cycle");
    dma_read(map_addr(p, ca), got);
    check_word("rddata", merge_byte(base, ca, r[7:0]), got);
    dma_read(da, got);
    check_word("rddata", ~base, got);
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    page_t       p;
    zaddr_t      ca [POOL];
    dram_word_t  shadow [POOL];
    dram_word_t  got;
    int          k;
    r = rand32();
    p = r[7:0];
    set_page(1, p);
    for (int i = 0; i < POOL; i++) begin
      r = rand32();
      ca[i] = {2'b01, r[9:0], i[2:0], 1'b0}; // low offset bits keep words apart
      shadow[i] = r[31:16];
      dma_write(map_addr(p, ca[i]), shadow[i]);
    end
    for (int n = 0; n < 24; n++) begin
      r = rand32();
      k = r[2:0];
      if (r[3]) begin
        shadow[k] = r[31:16];
        dma_write(map_addr(p, ca[k]), shadow[k]);
      end else begin
        ca[k][0] = r[4];
        shadow[k] = merge_byte(shadow[k], ca[k], r[15:8]);
        cpu_write(ca[k], r[15:8]);
      end
    end
    for (int i = 0; i < POOL; i++) begin
      dma_read(map_addr(p, ca[i]), got);
      check_word("rddata", shadow[i], got);
    end
  endtask

  initial begin
    fclk = 1'b0;
    arst_n = 1'b0;
    cpu_req = 1'b0;
    cpu_rnw = 1'b1;
    cpu_addr = '0;
    cpu_wrdata = '0;
    dma_req = 1'b0;
    dma_rnw = 1'b1;
    dma_addr = '0;
    dma_wrdata = '0;
    page_wr = 1'b0;
    page_win = '0;
    page_data = '0;
    repeat (RESET_CYCLES) @(posedge fclk);
    @(negedge fclk);
    arst_n = 1'b1;
    #1;
    test_reset();
    test_dma_round_trip();
    test_cpu_paging();
    test_page_remap();
    test_contention();
    test_random_mix();
    repeat (2) @(negedge fclk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tb.f */
src/mem_pkg.sv
src/dram_phase.sv
src/page_map.sv
src/dram_arbiter.sv
src/dram_ctrl.sv
src/zx_mem_core.sv
bench/dram_model.sv
bench/tb_zx_mem_core.sv

/* Bender.yml */
package:
  name: zx_mem_core

sources:
  - src/mem_pkg.sv
  - src/dram_phase.sv
  - src/page_map.sv
  - src/dram_arbiter.sv
  - src/dram_ctrl.sv
  - src/zx_mem_core.sv
  - target: test
    files:
      - bench/dram_model.sv
      - bench/tb_zx_mem_core.sv
